// File: hw/mmu_page_lookup.sv
// translation stage 1
// resolves I or D space for the request's mode, reads the page
// registers and registers them together with the request
`default_nettype none
`timescale 1ns/1ps

module mmu_page_lookup
   import mmu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 req_valid,
   input  wire mmu_req_t             req,
   input  wire mmu_ctl_t             ctl,
   output      logic [LOOKUP_AW-1:0] lookup_index,
   input  wire page_regs_t           lookup_regs,
   output      logic                 stage_valid,
   output      lookup_t              stage
);

   logic     d_enabled;
   logic     use_d;
   mmu_req_t req_eff;

   // mmr3 d space enable of the requesting mode
   always_comb
   begin
      case (req.mode)
         MODE_KERNEL: d_enabled = ctl.kern_d;
         MODE_SUPER:  d_enabled = ctl.supr_d;
         MODE_USER:   d_enabled = ctl.user_d;
         default:     d_enabled = 1'b0;
      endcase
   end

   // d space only when asked for and enabled, else fall back to i space
   assign use_d = req.dspace && d_enabled;

   // page number is the top three va bits
   assign lookup_index = {req.mode, use_d, req.va[15:13]};

   // carry the space actually used, mmr0 reports that one
   always_comb
   begin
      req_eff        = req;
      req_eff.dspace = use_d;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         stage_valid <= 1'b0;
      else
         stage_valid <= req_valid;
   end

   // payload, loaded only for a live request
   always_ff @(posedge clk)
   begin
      if (req_valid)
      begin
         stage.req    <= req_eff;
         stage.regs   <= lookup_regs;
         stage.enable <= ctl.enable;
      end
   end

endmodule

`default_nettype wire

// File: hw/mmu_pkg.sv
// KT-11 translation definitions
// processor modes, page register layout, request and response payloads
`default_nettype none

package mmu_pkg;

   localparam int VA_W           = 16;
   localparam int PA_W           = 18;
   localparam int LOOKUP_AW      = 6;
   localparam int NUM_PAGE_REGS  = 48;

   // processor modes, 10 is the illegal mode
   typedef logic [1:0] mode_t;
   localparam mode_t MODE_KERNEL  = 2'b00;
   localparam mode_t MODE_SUPER   = 2'b01;
   localparam mode_t MODE_ILLEGAL = 2'b10;
   localparam mode_t MODE_USER    = 2'b11;

   // simplified access control field
   localparam logic [1:0] ACF_NR0 = 2'b00;
   localparam logic [1:0] ACF_RO  = 2'b01;
   localparam logic [1:0] ACF_NR1 = 2'b10;
   localparam logic [1:0] ACF_RW  = 2'b11;

   // implemented bits of mmr0 and mmr3
   localparam logic [VA_W-1:0] MMR0_MASK = 16'he07f;
   localparam logic [VA_W-1:0] MMR3_MASK = 16'h0007;

   // pdr word; ed is kept but pages always grow upward
   typedef struct packed {
      logic       rsvd_15;
      logic [6:0] plf;
      logic [3:0] rsvd_7_4;
      logic       ed;
      logic [1:0] acf;
      logic       rsvd_0;
   } pdr_t;

   typedef struct packed {
      logic [VA_W-1:0] par;
      pdr_t            pdr;
   } page_regs_t;

   // mmr0 bit 0 and the mmr3 d space enables
   typedef struct packed {
      logic enable;
      logic kern_d;
      logic supr_d;
      logic user_d;
   } mmu_ctl_t;

   typedef struct packed {
      logic [VA_W-1:0] va;
      mode_t           mode;
      logic            dspace;
      logic            write;
   } mmu_req_t;

   // stage 1 to stage 2 payload
   typedef struct packed {
      mmu_req_t   req;
      page_regs_t regs;
      logic       enable;
   } lookup_t;

   // same order as mmr0 bits 15:13
   typedef struct packed {
      logic non_res;
      logic length;
      logic read_only;
   } abort_t;

   typedef struct packed {
      logic [PA_W-1:0] pa;
      abort_t          abort;
   } mmu_resp_t;

   typedef struct packed {
      abort_t          abort;
      mode_t           mode;
      logic            dspace;
      logic [2:0]      page;
      logic [VA_W-1:0] va;
   } abort_info_t;

endpackage

`default_nettype wire

// File: hw/mmu_reg_file.sv
// KT-11 register file
// holds par/pdr for three modes and both spaces plus mmr0, mmr2, mmr3
// serves the bus and the translation lookup, and captures abort status
`default_nettype none
`timescale 1ns/1ps

module mmu_reg_file
   import pdp11_bus_pkg::*, mmu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire pxr_bus_t             pxr,
   output      logic [WORD_W-1:0]    pxr_rdata,
   input  wire logic [LOOKUP_AW-1:0] lookup_index,
   output      page_regs_t           lookup_regs,
   output      mmu_ctl_t             ctl,
   input  wire logic                 abort_we,
   input  wire abort_info_t          abort_info,
   input  wire logic                 resp_done,
   input  wire logic [VA_W-1:0]      resp_va
);

   logic [WORD_W-1:0] par_mem [NUM_PAGE_REGS];
   logic [WORD_W-1:0] pdr_mem [NUM_PAGE_REGS];
   logic [WORD_W-1:0] mmr0;
   logic [WORD_W-1:0] mmr2;
   logic [WORD_W-1:0] mmr3;

   logic              bus_tbl_ok;
   logic [5:0]        bus_slot;
   logic              lkp_ok;
   logic [5:0]        lkp_slot;
   logic [WORD_W-1:0] rd_word;
   logic              mmr0_frozen;

   // pack {mode, space, page} into 0..47, mode 10 has no slot
   function automatic logic [5:0] slot_of(input logic [5:0] idx);
      logic [1:0] mode_slot;
      mode_slot = (idx[5:4] == MODE_USER) ? 2'd2 : {1'b0, idx[4]};
      return {mode_slot, idx[3:0]};
   endfunction

   function automatic logic [WORD_W-1:0] merge_bytes(input logic [WORD_W-1:0] old_word,
                                                     input logic [WORD_W-1:0] new_word,
                                                     input logic [1:0]        be);
      logic [WORD_W-1:0] result;
      result = old_word;
      if (be[0])
         result[7:0] = new_word[7:0];
      if (be[1])
         result[15:8] = new_word[15:8];
      return result;
   endfunction

   assign bus_tbl_ok = !pxr.index[7] && (pxr.index[5:4] != MODE_ILLEGAL);
   assign bus_slot   = slot_of(pxr.index[5:0]);
   assign lkp_ok     = lookup_index[5:4] != MODE_ILLEGAL;
   assign lkp_slot   = slot_of(lookup_index);

   // any abort bit set freezes mmr0 and mmr2
   assign mmr0_frozen = |mmr0[15:13];

   // bus read port
   always_comb
   begin
      rd_word = '0;
      case (pxr.index)
         MMR0_IDX: rd_word = mmr0;
         // mmr1 tracking not implemented
         MMR1_IDX: rd_word = '0;
         MMR2_IDX: rd_word = mmr2;
         MMR3_IDX: rd_word = mmr3;
         default:
         begin
            if (bus_tbl_ok)
               rd_word = pxr.index[6] ? par_mem[bus_slot] : pdr_mem[bus_slot];
         end
      endcase
   end

   assign pxr_rdata = pxr.rd ? rd_word : '0;

   // lookup read port, illegal mode sees a zero (non-resident) pdr
   assign lookup_regs.par = lkp_ok ? par_mem[lkp_slot] : '0;
   assign lookup_regs.pdr = lkp_ok ? pdr_mem[lkp_slot] : '0;

   assign ctl.enable = mmr0[0];
   assign ctl.kern_d = mmr3[2];
   assign ctl.supr_d = mmr3[1];
   assign ctl.user_d = mmr3[0];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_PAGE_REGS; i++)
         begin
            par_mem[i] <= '0;
            pdr_mem[i] <= '0;
         end
         mmr0 <= '0;
         mmr2 <= '0;
         mmr3 <= '0;
      end
      else
      begin
         if (pxr.wr && bus_tbl_ok)
         begin
            if (pxr.index[6])
               par_mem[bus_slot] <= merge_bytes(par_mem[bus_slot], pxr.wdata, pxr.be);
            else
               pdr_mem[bus_slot] <= merge_bytes(pdr_mem[bus_slot], pxr.wdata, pxr.be);
         end
         if (pxr.wr && pxr.index == MMR0_IDX)
            mmr0 <= merge_bytes(mmr0, pxr.wdata, pxr.be) & MMR0_MASK;
         if (pxr.wr && pxr.index == MMR3_IDX)
            mmr3 <= merge_bytes(mmr3, pxr.wdata, pxr.be) & MMR3_MASK;

         // first abort wins over a bus write in the same cycle
         if (abort_we && !mmr0_frozen)
         begin
            mmr0 <= {abort_info.abort, 6'b0, abort_info.mode, abort_info.dspace,
                     abort_info.page, mmr0[0]};
            mmr2 <= abort_info.va;
         end
         else if (resp_done && !abort_we && !mmr0_frozen)
            // track the last good va while not frozen
            mmr2 <= resp_va;
      end
   end

endmodule

`default_nettype wire

// File: hw/mmu_regs.sv
// KT-11 I/O page decoder
// maps bus addresses of mmr0..mmr3 and the par/pdr windows onto
// register file indices, builds byte enables and steers read lanes
`default_nettype none
`timescale 1ns/1ps

module mmu_regs
   import pdp11_bus_pkg::*, mmu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic [IOPAGE_AW-1:0] iopage_addr,
   input  wire logic [WORD_W-1:0]    data_in,
   input  wire logic                 iopage_rd,
   input  wire logic                 iopage_wr,
   input  wire logic                 iopage_byte_op,
   output      logic [WORD_W-1:0]    data_out,
   output      logic                 decode,
   output      pxr_bus_t             pxr,
   input  wire logic [WORD_W-1:0]    pxr_rdata
);

   logic [IOPAGE_AW-1:0] word_addr;
   logic                 user_win;
   logic                 supr_win;
   logic                 kern_win;
   logic                 mmr_hit;
   logic [PXR_AW-1:0]    index;

   // mmr decode ignores the byte bit
   assign word_addr = {iopage_addr[IOPAGE_AW-1:1], 1'b0};

   // each window spans 64 bytes, so match above bit 5
   assign user_win = iopage_addr[IOPAGE_AW-1:6] == USER_BASE[IOPAGE_AW-1:6];
   assign supr_win = iopage_addr[IOPAGE_AW-1:6] == SUPR_BASE[IOPAGE_AW-1:6];
   assign kern_win = iopage_addr[IOPAGE_AW-1:6] == KERN_BASE[IOPAGE_AW-1:6];

   assign mmr_hit = (word_addr == MMR0_ADDR) || (word_addr == MMR1_ADDR) ||
                    (word_addr == MMR2_ADDR) || (word_addr == MMR3_ADDR);

   assign decode = mmr_hit || user_win || supr_win || kern_win;

   // register file index
   // addr bit 5 picks par over pdr, bit 4 d space, bits 3:1 the page
   always_comb
   begin
      index = '0;
      if (word_addr == MMR0_ADDR)
         index = MMR0_IDX;
      else if (word_addr == MMR1_ADDR)
         index = MMR1_IDX;
      else if (word_addr == MMR2_ADDR)
         index = MMR2_IDX;
      else if (word_addr == MMR3_ADDR)
         index = MMR3_IDX;
      else if (user_win)
         index = {1'b0, iopage_addr[5], MODE_USER, iopage_addr[4:1]};
      else if (supr_win)
         index = {1'b0, iopage_addr[5], MODE_SUPER, iopage_addr[4:1]};
      else if (kern_win)
         index = {1'b0, iopage_addr[5], MODE_KERNEL, iopage_addr[4:1]};
   end

   // strobes only reach the register file for our own addresses
   assign pxr.rd    = iopage_rd && decode;
   assign pxr.wr    = iopage_wr && decode;
   assign pxr.index = index;
   assign pxr.wdata = data_in;

   // odd address selects the high lane on byte ops
   assign pxr.be = iopage_byte_op ? {iopage_addr[0], ~iopage_addr[0]} : 2'b11;

   // byte reads come back zero extended in the low lane
   always_comb
   begin
      if (iopage_byte_op)
         data_out = {8'b0, iopage_addr[0] ? pxr_rdata[15:8] : pxr_rdata[7:0]};
      else
         data_out = pxr_rdata;
   end

endmodule

`default_nettype wire

// File: hw/mmu_relocate.sv
// translation stage 2
// forms the 18 bit physical address from par and offset, checks
// residency, length and write protection, registers the response
`default_nettype none
`timescale 1ns/1ps

module mmu_relocate
   import mmu_pkg::*;
(
   input  wire logic            clk,
   input  wire logic            reset,
   input  wire logic            stage_valid,
   input  wire lookup_t         stage,
   output      logic            resp_valid,
   output      mmu_resp_t       resp,
   output      logic            trap,
   output      abort_info_t     abort_info,
   output      logic [VA_W-1:0] resp_va
);

   logic [PA_W-1:0] base;
   logic [PA_W-1:0] pa_mapped;
   logic [6:0]      block;
   logic [1:0]      acf;
   abort_t          checks;
   mmu_resp_t       resp_next;

   // par counts 64 byte blocks, upper par bits fall off at 18 bits
   assign base      = {stage.regs.par[PA_W-7:0], 6'b0};
   assign pa_mapped = base + {{(PA_W-13){1'b0}}, stage.req.va[12:0]};

   // block number within the page, compared against plf
   assign block = stage.req.va[12:6];
   assign acf   = stage.regs.pdr.acf;

   assign checks.non_res   = (acf == ACF_NR0) || (acf == ACF_NR1) ||
                             (stage.req.mode == MODE_ILLEGAL);
   assign checks.length    = block > stage.regs.pdr.plf;
   assign checks.read_only = stage.req.write && (acf == ACF_RO);

   // translation off means identity map and no aborts
   always_comb
   begin
      if (stage.enable)
      begin
         resp_next.pa    = pa_mapped;
         resp_next.abort = checks;
      end
      else
      begin
         resp_next.pa    = {{(PA_W-VA_W){1'b0}}, stage.req.va};
         resp_next.abort = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         resp_valid <= 1'b0;
         trap       <= 1'b0;
      end
      else
      begin
         resp_valid <= stage_valid;
         // trap pulses with the aborted response
         trap       <= stage_valid && (|resp_next.abort);
      end
   end

   // response and abort details for mmr0/mmr2
   always_ff @(posedge clk)
   begin
      resp              <= resp_next;
      resp_va           <= stage.req.va;
      abort_info.abort  <= resp_next.abort;
      abort_info.mode   <= stage.req.mode;
      abort_info.dspace <= stage.req.dspace;
      abort_info.page   <= stage.req.va[15:13];
      abort_info.va     <= stage.req.va;
   end

endmodule

`default_nettype wire

// File: hw/mmu_subsystem.sv
// KT-11 memory management unit top level
// I/O page register access plus a two stage address translation pipe
`default_nettype none
`timescale 1ns/1ps

module mmu_subsystem
   import pdp11_bus_pkg::*, mmu_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 reset,
   // i/o page bus
   input  wire logic [IOPAGE_AW-1:0] iopage_addr,
   input  wire logic [WORD_W-1:0]    data_in,
   input  wire logic                 iopage_rd,
   input  wire logic                 iopage_wr,
   input  wire logic                 iopage_byte_op,
   output      logic [WORD_W-1:0]    data_out,
   output      logic                 decode,
   // translation
   input  wire logic                 req_valid,
   input  wire mmu_req_t             req,
   output      logic                 resp_valid,
   output      mmu_resp_t            resp,
   output      logic                 trap
);

   pxr_bus_t             pxr;
   logic [WORD_W-1:0]    pxr_rdata;
   logic [LOOKUP_AW-1:0] lookup_index;
   page_regs_t           lookup_regs;
   mmu_ctl_t             ctl;
   logic                 stage_valid;
   lookup_t              stage;
   abort_info_t          abort_info;
   logic [VA_W-1:0]      resp_va;

   mmu_regs i_regs (
      .clk            (clk),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .data_out       (data_out),
      .decode         (decode),
      .pxr            (pxr),
      .pxr_rdata      (pxr_rdata)
   );

   // abort capture rides on the trap pulse, mmr2 tracking on resp_valid
   mmu_reg_file i_reg_file (
      .clk          (clk),
      .reset        (reset),
      .pxr          (pxr),
      .pxr_rdata    (pxr_rdata),
      .lookup_index (lookup_index),
      .lookup_regs  (lookup_regs),
      .ctl          (ctl),
      .abort_we     (trap),
      .abort_info   (abort_info),
      .resp_done    (resp_valid),
      .resp_va      (resp_va)
   );

   mmu_page_lookup i_page_lookup (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req          (req),
      .ctl          (ctl),
      .lookup_index (lookup_index),
      .lookup_regs  (lookup_regs),
      .stage_valid  (stage_valid),
      .stage        (stage)
   );

   mmu_relocate i_relocate (
      .clk         (clk),
      .reset       (reset),
      .stage_valid (stage_valid),
      .stage       (stage),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .trap        (trap),
      .abort_info  (abort_info),
      .resp_va     (resp_va)
   );

endmodule

`default_nettype wire

// File: hw/pdp11_bus_pkg.sv
// PDP-11 I/O page bus definitions for the KT-11 register block
// covers bus widths, register addresses and the decoder to register
// file access struct
`default_nettype none

package pdp11_bus_pkg;

   // bus widths
   localparam int IOPAGE_AW = 13;
   localparam int WORD_W    = 16;
   localparam int PXR_AW    = 8;

   // mmr addresses within the i/o page, octal as on the unibus
   localparam logic [IOPAGE_AW-1:0] MMR0_ADDR = 13'o17572;
   localparam logic [IOPAGE_AW-1:0] MMR1_ADDR = 13'o17574;
   localparam logic [IOPAGE_AW-1:0] MMR2_ADDR = 13'o17576;
   localparam logic [IOPAGE_AW-1:0] MMR3_ADDR = 13'o12516;

   // base of each 64 byte par/pdr window
   localparam logic [IOPAGE_AW-1:0] USER_BASE = 13'o17600;
   localparam logic [IOPAGE_AW-1:0] SUPR_BASE = 13'o12200;
   localparam logic [IOPAGE_AW-1:0] KERN_BASE = 13'o12300;

   // register file indices of mmr0..mmr3, bit 7 set
   localparam logic [PXR_AW-1:0] MMR0_IDX = 8'h80;
   localparam logic [PXR_AW-1:0] MMR1_IDX = 8'h81;
   localparam logic [PXR_AW-1:0] MMR2_IDX = 8'h82;
   localparam logic [PXR_AW-1:0] MMR3_IDX = 8'h83;

   // one register access from the decoder
   // index: [7] mmr, [6] par, [5:4] mode, [3] d space, [2:0] page
   typedef struct packed {
      logic              rd;
      logic              wr;
      logic [1:0]        be;
      logic [PXR_AW-1:0] index;
      logic [WORD_W-1:0] wdata;
   } pxr_bus_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the MMU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f tb.f --top-module tb_mmu -o tb_mmu_sim
output="$(./obj_dir/tb_mmu_sim)"
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1

// File: tb.f
+incdir+testbench
hw/pdp11_bus_pkg.sv
hw/mmu_pkg.sv
hw/mmu_regs.sv
hw/mmu_reg_file.sv
hw/mmu_page_lookup.sv
hw/mmu_relocate.sv
hw/mmu_subsystem.sv
testbench/tb_mmu.sv

// File: testbench/tb_mmu_tests.svh
// directed tests for the KT-11 MMU testbench
// register access, identity map, relocation, aborts, D space, pipelining

// every par/pdr and mmr3 written then read back, plus byte lanes
task automatic register_access();
   logic [31:0] rnd;
   logic [12:0] addr;
   for (int m = 0; m < 3; m++)
      for (int d = 0; d < 2; d++)
         for (int p = 0; p < 8; p++)
         begin
            rnd = next_rand();
            set_page_reg(1'b1, pick_mode(m[1:0]), d[0], p[2:0], rnd[15:0]);
            set_page_reg(1'b0, pick_mode(m[1:0]), d[0], p[2:0], rnd[31:16]);
         end
   rnd = next_rand();
   set_mmr3(rnd[15:0]);
   for (int m = 0; m < 3; m++)
      for (int d = 0; d < 2; d++)
         for (int p = 0; p < 8; p++)
         begin
            read_expect(reg_addr(1'b1, pick_mode(m[1:0]), d[0], p[2:0]), 1'b0,
                        par_sh[pick_mode(m[1:0])][d[0]][p[2:0]], "par");
            read_expect(reg_addr(1'b0, pick_mode(m[1:0]), d[0], p[2:0]), 1'b0,
                        pdr_sh[pick_mode(m[1:0])][d[0]][p[2:0]], "pdr");
         end
   // only the three D enables exist in mmr3
   read_expect(MMR3_ADDR, 1'b0, {13'b0, mmr3_sh}, "mmr3");
   read_expect(MMR1_ADDR, 1'b0, 16'h0000, "mmr1");

   // byte lanes on user I par 1, odd address is the high byte
   addr = reg_addr(1'b1, MODE_USER, 1'b0, 3'd1);
   write_byte(addr, 8'h5a);
   par_sh[MODE_USER][1'b0][3'd1][7:0] = 8'h5a;
   write_byte(addr | 13'd1, 8'hc3);
   par_sh[MODE_USER][1'b0][3'd1][15:8] = 8'hc3;
   read_expect(addr, 1'b0, par_sh[MODE_USER][1'b0][3'd1], "par word");
   read_expect(addr, 1'b1, {8'h00, par_sh[MODE_USER][1'b0][3'd1][7:0]}, "par low byte");
   read_expect(addr | 13'd1, 1'b1, {8'h00, par_sh[MODE_USER][1'b0][3'd1][15:8]},
               "par high byte");

   // nothing of ours lives at 10000 octal
   @(negedge clk);
   iopage_addr = 13'o10000;
   iopage_rd   = 1'b1;
   #1;
   if (decode !== 1'b0)
      report_mismatch("decode", 32'd0, {31'b0, decode});
   @(negedge clk);
   iopage_rd = 1'b0;
endtask

// translation still off after reset, identity map
task automatic translation_off();
   logic [31:0] rnd;
   for (int i = 0; i < 8; i++)
   begin
      rnd = next_rand();
      send_request(pick_mode(rnd[1:0]), rnd[2], rnd[3], rnd[31:16]);
   end
endtask

task automatic relocation();
   logic [31:0] rnd;
   set_mmr3(16'h0000);
   // resident read/write pages, full length
   for (int m = 0; m < 3; m++)
      for (int d = 0; d < 2; d++)
         for (int p = 0; p < 8; p++)
         begin
            rnd = next_rand();
            set_page_reg(1'b1, pick_mode(m[1:0]), d[0], p[2:0], rnd[15:0]);
            set_page_reg(1'b0, pick_mode(m[1:0]), d[0], p[2:0], 16'h7f06);
         end
   write_word(MMR0_ADDR, 16'h0001);
   enable_sh = 1'b1;
   read_expect(MMR0_ADDR, 1'b0, 16'h0001, "mmr0");
   for (int i = 0; i < 24; i++)
   begin
      rnd = next_rand();
      send_request(pick_mode(rnd[1:0]), rnd[2], rnd[3], rnd[31:16]);
   end
endtask

task automatic abort_capture();
   logic [15:0] va_first;
   logic [15:0] va_ro;
   // non-resident kernel I page 2
   set_page_reg(1'b0, MODE_KERNEL, 1'b0, 3'd2, 16'h7f00);
   va_first = {3'd2, 13'h0a4c};
   send_request(MODE_KERNEL, 1'b0, 1'b0, va_first);
   // abort bit 15, kernel, I space, page 2, enable
   read_expect(MMR0_ADDR, 1'b0, 16'h8005, "mmr0");
   read_expect(MMR2_ADDR, 1'b0, va_first, "mmr2");

   // user I page 3 only 6 blocks long, second abort leaves mmr0/mmr2 alone
   set_page_reg(1'b0, MODE_USER, 1'b0, 3'd3, 16'h0506);
   send_request(MODE_USER, 1'b0, 1'b0, {3'd3, 7'd10, 6'h15});
   read_expect(MMR0_ADDR, 1'b0, 16'h8005, "mmr0");
   read_expect(MMR2_ADDR, 1'b0, va_first, "mmr2");

   write_word(MMR0_ADDR, 16'h0001);
   read_expect(MMR0_ADDR, 1'b0, 16'h0001, "mmr0");

   // supervisor I page 4 read-only, a read passes and a write aborts
   set_page_reg(1'b0, MODE_SUPER, 1'b0, 3'd4, 16'h7f02);
   send_request(MODE_SUPER, 1'b0, 1'b0, {3'd4, 13'h0123});
   va_ro = {3'd4, 13'h1ffe};
   send_request(MODE_SUPER, 1'b0, 1'b1, va_ro);
   read_expect(MMR0_ADDR, 1'b0, 16'h2029, "mmr0");
   read_expect(MMR2_ADDR, 1'b0, va_ro, "mmr2");
   write_word(MMR0_ADDR, 16'h0001);
endtask

// page 5 gets different I and D bases in every mode
task automatic dspace_select();
   logic [31:0] rnd;
   for (int m = 0; m < 3; m++)
   begin
      rnd = next_rand();
      set_page_reg(1'b1, pick_mode(m[1:0]), 1'b0, 3'd5, rnd[15:0]);
      set_page_reg(1'b1, pick_mode(m[1:0]), 1'b1, 3'd5, ~rnd[15:0]);
      set_page_reg(1'b0, pick_mode(m[1:0]), 1'b0, 3'd5, 16'h7f06);
      set_page_reg(1'b0, pick_mode(m[1:0]), 1'b1, 3'd5, 16'h7f06);
   end
   // D enables clear, D requests fall back to I
   set_mmr3(16'h0000);
   for (int m = 0; m < 3; m++)
   begin
      rnd = next_rand();
      send_request(pick_mode(m[1:0]), 1'b1, 1'b0, {3'd5, rnd[12:0]});
   end
   // only one mode has its D enable set per pass
   for (int en = 0; en < 3; en++)
   begin
      set_mmr3(16'h0001 << en);
      for (int m = 0; m < 3; m++)
      begin
         rnd = next_rand();
         send_request(pick_mode(m[1:0]), 1'b1, 1'b0, {3'd5, rnd[12:0]});
      end
   end
endtask

// one request per cycle, forced aborts among random ones
task automatic back_to_back();
   logic [31:0] rnd;
   mode_t       m;
   logic        d;
   logic        w;
   logic [15:0] va;
   for (int i = 0; i < 16; i++)
   begin
      rnd = next_rand();
      m   = pick_mode(rnd[1:0]);
      d   = rnd[3];
      w   = rnd[2];
      va  = rnd[31:16];
      if (i % 4 == 0)
      begin
         m = MODE_KERNEL;
         d = 1'b0;
         va[15:13] = 3'd2;
      end
      else if (i % 4 == 1)
      begin
         m = MODE_USER;
         d = 1'b0;
         va[15:13] = 3'd3;
         va[12:6]  = 7'd100;
      end
      @(negedge clk);
      drive_request(m, d, w, va);
   end
   @(negedge clk);
   req_valid = 1'b0;
   drain_responses();
endtask

// File: testbench/tb_mmu.sv
// testbench for the KT-11 memory management unit
// drives the I/O page bus and the translation port, keeps a shadow of
// the page registers and predicts every translation response
`default_nettype none
`timescale 1ns/1ps

module tb_mmu
   import pdp11_bus_pkg::*, mmu_pkg::*;
();

   // tests run for about 1500 cycles
   localparam int TIMEOUT_CYCLES = 5000;

   typedef struct packed {
      logic [31:0] cycle;
      mmu_resp_t   resp;
   } expect_t;

   logic                 clk;
   logic                 reset;
   logic [IOPAGE_AW-1:0] iopage_addr;
   logic [WORD_W-1:0]    data_in;
   logic                 iopage_rd;
   logic                 iopage_wr;
   logic                 iopage_byte_op;
   logic [WORD_W-1:0]    data_out;
   logic                 decode;
   logic                 req_valid;
   mmu_req_t             req;
   logic                 resp_valid;
   mmu_resp_t            resp;
   logic                 trap;

   int          errors = 0;
   int          cycles;
   logic [31:0] lcg_state = 32'hc5a4;
   expect_t     expected[$];

   // shadow of the register file, [mode][d space][page]
   logic [15:0] par_sh [4][2][8];
   logic [15:0] pdr_sh [4][2][8];
   logic [2:0]  mmr3_sh;
   logic        enable_sh;

   mmu_subsystem i_dut (
      .clk            (clk),
      .reset          (reset),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .data_out       (data_out),
      .decode         (decode),
      .req_valid      (req_valid),
      .req            (req),
      .resp_valid     (resp_valid),
      .resp           (resp),
      .trap           (trap)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("Error: %0t run did not finish within %0d cycles", $time, TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("Error: %0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
   endtask

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic mode_t pick_mode(input logic [1:0] sel);
      if (sel == 2'd0)
         return MODE_KERNEL;
      else if (sel == 2'd1)
         return MODE_SUPER;
      return MODE_USER;
   endfunction

   // window base, then bit 5 par, bit 4 d space, bits 3:1 page
   function automatic logic [12:0] reg_addr(input logic is_par, input mode_t m,
                                            input logic d, input logic [2:0] page);
      logic [12:0] base;
      base = (m == MODE_KERNEL) ? KERN_BASE : (m == MODE_SUPER) ? SUPR_BASE : USER_BASE;
      return base + {7'b0, is_par, d, page, 1'b0};
   endfunction

   // expected response from the shadow registers
   function automatic expect_t predict(input mmu_req_t r);
      expect_t     e;
      logic        use_d;
      logic [15:0] par;
      logic [15:0] pdr;
      logic [21:0] full;
      case (r.mode)
         MODE_KERNEL: use_d = r.dspace && mmr3_sh[2];
         MODE_SUPER:  use_d = r.dspace && mmr3_sh[1];
         default:     use_d = r.dspace && mmr3_sh[0];
      endcase
      par = par_sh[r.mode][use_d][r.va[15:13]];
      pdr = pdr_sh[r.mode][use_d][r.va[15:13]];
      // par counts 64 byte blocks
      full = {par, 6'b0} + {9'b0, r.va[12:0]};
      e.cycle = cycles;
      e.resp.abort = '0;
      if (enable_sh)
      begin
         e.resp.pa = full[17:0];
         e.resp.abort.non_res = (pdr[2:1] == 2'b00) || (pdr[2:1] == 2'b10) ||
                                (r.mode == 2'b10);
         e.resp.abort.length = r.va[12:6] > pdr[14:8];
         e.resp.abort.read_only = r.write && (pdr[2:1] == 2'b01);
      end
      else
         e.resp.pa = {2'b00, r.va};
      return e;
   endfunction

   task automatic write_word(input logic [12:0] addr, input logic [15:0] value);
      @(negedge clk);
      iopage_addr    = addr;
      data_in        = value;
      iopage_byte_op = 1'b0;
      iopage_wr      = 1'b1;
      @(negedge clk);
      iopage_wr = 1'b0;
   endtask

   // the byte goes out on both lanes
   task automatic write_byte(input logic [12:0] addr, input logic [7:0] value);
      @(negedge clk);
      iopage_addr    = addr;
      data_in        = {value, value};
      iopage_byte_op = 1'b1;
      iopage_wr      = 1'b1;
      @(negedge clk);
      iopage_wr      = 1'b0;
      iopage_byte_op = 1'b0;
   endtask

   // read data is combinational, sampled mid cycle
   task automatic read_expect(input logic [12:0] addr, input logic byte_op,
                              input logic [15:0] exp, input string name);
      @(negedge clk);
      iopage_addr    = addr;
      iopage_byte_op = byte_op;
      iopage_rd      = 1'b1;
      #1;
      if (decode !== 1'b1)
         report_mismatch("decode", 32'd1, {31'b0, decode});
      if (data_out !== exp)
         report_mismatch(name, {16'h0, exp}, {16'h0, data_out});
      @(negedge clk);
      iopage_rd      = 1'b0;
      iopage_byte_op = 1'b0;
   endtask

   task automatic set_page_reg(input logic is_par, input mode_t m, input logic d,
                               input logic [2:0] page, input logic [15:0] value);
      write_word(reg_addr(is_par, m, d, page), value);
      if (is_par)
         par_sh[m][d][page] = value;
      else
         pdr_sh[m][d][page] = value;
   endtask

   task automatic set_mmr3(input logic [15:0] value);
      write_word(MMR3_ADDR, value);
      mmr3_sh = value[2:0];
   endtask

   // called at a falling edge, leaves req_valid high
   task automatic drive_request(input mode_t m, input logic d, input logic w,
                                input logic [15:0] va);
      req       = {va, m, d, w};
      req_valid = 1'b1;
      expected.push_back(predict(req));
   endtask

   task automatic drain_responses();
      while (expected.size() != 0)
         @(negedge clk);
   endtask

   task automatic send_request(input mode_t m, input logic d, input logic w,
                               input logic [15:0] va);
      @(negedge clk);
      drive_request(m, d, w, va);
      @(negedge clk);
      req_valid = 1'b0;
      drain_responses();
   endtask

   // compares each response with the oldest prediction
   task automatic check_responses();
      expect_t front;
      forever
      begin
         @(negedge clk);
         if (resp_valid)
         begin
            if (expected.size() == 0)
            begin
               $display("Error: %0t response arrived with no request outstanding", $time);
               errors++;
            end
            else
            begin
               front = expected.pop_front();
               if (cycles - front.cycle != 2)
                  report_mismatch("latency", 32'd2, cycles - front.cycle);
               if (resp.pa !== front.resp.pa)
                  report_mismatch("resp.pa", {14'b0, front.resp.pa}, {14'b0, resp.pa});
               if (resp.abort !== front.resp.abort)
                  report_mismatch("resp.abort", {29'b0, front.resp.abort},
                                  {29'b0, resp.abort});
               if (trap !== (|front.resp.abort))
                  report_mismatch("trap", {31'b0, |front.resp.abort}, {31'b0, trap});
            end
         end
         else if (trap)
         begin
            $display("Error: %0t trap pulsed without a response", $time);
            errors++;
         end
      end
   endtask

   `include "tb_mmu_tests.svh"

   initial
   begin
      reset          = 1'b1;
      iopage_addr    = '0;
      data_in        = '0;
      iopage_rd      = 1'b0;
      iopage_wr      = 1'b0;
      iopage_byte_op = 1'b0;
      req_valid      = 1'b0;
      req            = '0;
      mmr3_sh        = 3'b0;
      enable_sh      = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      fork
         check_responses();
      join_none
      register_access();
      translation_off();
      relocation();
      abort_capture();
      dspace_select();
      back_to_back();
      drain_responses();
      $display("tb_mmu: %0d errors", errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
